// File: include/merge_cfg.svh
// --------------------------------------------------------------------
// Configuration macros for the merge data generator
// Lane count, field and meta widths, packet count width, FIFO sizing
// --------------------------------------------------------------------

`ifndef MERGE_CFG_SVH
`define MERGE_CFG_SVH

// Number of input lanes merged into one packet
`define MERGE_LANES 4

// Payload widths
`define MERGE_FIELD_W 32
`define MERGE_META_W 16

// Packets per run
`define MERGE_COUNT_W 16

// Threshold leaves headroom below full
`define MERGE_FIFO_DEPTH 16
`define MERGE_PROG_THRESH 8

`endif

// File: logic/merge_pkg.sv
// --------------------------------------------------------------------
// Data types and control state encoding for the merge data generator
// --------------------------------------------------------------------

package merge_pkg;

`include "merge_cfg.svh"

    // ----------------------------------------------------------------
    // Payload types
    // ----------------------------------------------------------------
    typedef logic [`MERGE_FIELD_W-1:0] field_t;
    typedef logic [`MERGE_META_W-1:0]  meta_t;

    // A set bit enables its lane
    typedef logic [`MERGE_LANES-1:0] lane_mask_t;

    // Lane 0 field sits in the low bits
    typedef logic [`MERGE_LANES*`MERGE_FIELD_W-1:0] packet_data_t;

    typedef logic [`MERGE_COUNT_W-1:0] pkt_count_t;

    // ----------------------------------------------------------------
    // Run control FSM
    // ----------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CFG_ACK,
        ST_BUSY,
        ST_PAUSE,
        ST_DONE
    } merge_state_t;

endpackage : merge_pkg

// File: logic/merge_fifo.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Synchronous first-word-fall-through FIFO
// Full, empty and programmable-full flags from an occupancy count
// --------------------------------------------------------------------

`include "merge_cfg.svh"

module merge_fifo #(
    parameter int WIDTH       = `MERGE_META_W + `MERGE_FIELD_W,
    parameter int DEPTH       = `MERGE_FIFO_DEPTH,
    parameter int PROG_THRESH = `MERGE_PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Head entry always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // ----------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Upstream flow control keeps writes off a full FIFO
    assert property (@(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full)
        else $error("merge_fifo write while full");

    // Readers must check empty before popping
    assert property (@(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty)
        else $error("merge_fifo read while empty");

endmodule : merge_fifo

// File: logic/merge_control.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Run control FSM for the merge data generator
// Four-phase configuration handshake, packet counting, pause and done
// --------------------------------------------------------------------

module merge_control (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  cfg_req,
    input  merge_pkg::lane_mask_t cfg_mask,
    input  merge_pkg::pkt_count_t cfg_count,
    input  logic                  merge_fire,
    input  logic                  prog_full,
    output logic                  cfg_ack,
    output merge_pkg::lane_mask_t lane_mask,
    output logic                  run,
    output logic                  done
);

    import merge_pkg::*;

    // ----------------------------------------------------------------
    // State and counters
    // ----------------------------------------------------------------
    merge_state_t state;
    merge_state_t next_state;
    pkt_count_t   remaining;
    logic         cfg_accept;
    logic         last_fire;

    // Configuration taken only between runs
    assign cfg_accept = cfg_req & ((state == ST_IDLE) | (state == ST_DONE));

    // Merge that completes the configured count
    assign last_fire = merge_fire & (remaining == pkt_count_t'(1));

    // ----------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (cfg_req) begin
                    next_state = ST_CFG_ACK;
                end
            end
            ST_CFG_ACK: begin
                // Wait for the host to drop its request
                if (!cfg_req) begin
                    if (remaining == '0) begin
                        next_state = ST_DONE;
                    end
                    else begin
                        next_state = ST_BUSY;
                    end
                end
            end
            ST_BUSY: begin
                if (last_fire) begin
                    next_state = ST_DONE;
                end
                else if (prog_full) begin
                    next_state = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (!prog_full) begin
                    next_state = ST_BUSY;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------
    // State register, configuration latch, packet counter
    // ----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state     <= ST_IDLE;
            lane_mask <= '0;
            remaining <= '0;
        end
        else begin
            state <= next_state;
            if (cfg_accept) begin
                lane_mask <= cfg_mask;
                remaining <= cfg_count;
            end
            else if (merge_fire) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // Outputs decoded straight from the state
    assign cfg_ack = (state == ST_CFG_ACK);
    assign run     = (state == ST_BUSY);
    assign done    = (state == ST_DONE);

    // ----------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------
    // Lane 0 carries the meta word, so it has to be enabled
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        cfg_accept |-> cfg_mask[0])
        else $error("merge_control run accepted with lane 0 masked");

    // Combiner only completes packets while the run is active
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        merge_fire |-> (state == ST_BUSY))
        else $error("merge_control merge_fire outside busy");

endmodule : merge_control

// File: logic/merge_combiner.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Merge combiner
// Per-lane capture flags, lane pops and merged packet register
// --------------------------------------------------------------------

`include "merge_cfg.svh"

module merge_combiner (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    run,
    input  merge_pkg::lane_mask_t   lane_mask,
    input  logic [`MERGE_LANES-1:0] lane_empty,
    input  merge_pkg::meta_t        lane_meta [`MERGE_LANES],
    input  merge_pkg::field_t       lane_field [`MERGE_LANES],
    output logic [`MERGE_LANES-1:0] lane_pop,
    output logic                    merge_fire,
    output merge_pkg::meta_t        pkt_meta,
    output merge_pkg::packet_data_t pkt_data
);

    import merge_pkg::*;

    localparam int FW = $bits(field_t);

    lane_mask_t captured;
    lane_mask_t take;
    lane_mask_t drop;
    logic       all_captured;

    // ----------------------------------------------------------------
    // Lane pops
    // ----------------------------------------------------------------
    // Masked lanes count as already captured
    assign all_captured = &(captured | ~lane_mask);
    assign merge_fire   = run & all_captured;

    // Enabled lane with data that still owes a field
    assign take = {`MERGE_LANES{run}} & lane_mask & ~lane_empty & ~captured;

    // Masked lanes drained and discarded
    assign drop = ~lane_mask & ~lane_empty;

    assign lane_pop = take | drop;

    // ----------------------------------------------------------------
    // Capture flags
    // ----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            captured <= '0;
        end
        else if (merge_fire) begin
            captured <= '0;
        end
        else begin
            captured <= captured | take;
        end
    end

    // ----------------------------------------------------------------
    // Packet register
    // ----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (take[0]) begin
            pkt_meta <= lane_meta[0];
        end
        for (int i = 0; i < `MERGE_LANES; i++) begin
            if (take[i]) begin
                pkt_data[i*FW +: FW] <= lane_field[i];
            end
            else if (!lane_mask[i]) begin
                // Disabled lanes contribute zero
                pkt_data[i*FW +: FW] <= '0;
            end
        end
    end

    // Mask comes from control and may never see a capture on a masked lane
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (captured & ~lane_mask) == '0)
        else $error("merge_combiner captured a masked lane");

endmodule : merge_combiner

// File: logic/merge_data_generator.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Merge data generator top level
// Lane FIFOs, run control, combiner and output FIFO
// --------------------------------------------------------------------

`include "merge_cfg.svh"

module merge_data_generator (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    cfg_req,
    input  merge_pkg::lane_mask_t   cfg_mask,
    input  merge_pkg::pkt_count_t   cfg_count,
    input  logic [`MERGE_LANES-1:0] lane_valid,
    input  merge_pkg::meta_t        lane_meta [`MERGE_LANES],
    input  merge_pkg::field_t       lane_field [`MERGE_LANES],
    input  logic                    out_pop,
    output logic                    cfg_ack,
    output logic                    done,
    output logic [`MERGE_LANES-1:0] lane_ready,
    output logic                    out_valid,
    output merge_pkg::meta_t        out_meta,
    output merge_pkg::packet_data_t out_data
);

    import merge_pkg::*;

    localparam int LANE_W = $bits(meta_t) + $bits(field_t);
    localparam int OUT_W  = $bits(meta_t) + $bits(packet_data_t);

    // ----------------------------------------------------------------
    // Internal wires
    // ----------------------------------------------------------------
    logic [`MERGE_LANES-1:0] lane_full;
    logic [`MERGE_LANES-1:0] lane_empty;
    logic [`MERGE_LANES-1:0] lane_pop;
    logic [LANE_W-1:0]       lane_dout [`MERGE_LANES];
    meta_t                   fifo_meta [`MERGE_LANES];
    field_t                  fifo_field [`MERGE_LANES];

    lane_mask_t   lane_mask;
    logic         run;
    logic         merge_fire;
    meta_t        pkt_meta;
    packet_data_t pkt_data;

    logic             out_empty;
    logic             out_prog_full;
    logic             out_rd;
    logic [OUT_W-1:0] out_dout;

    // ----------------------------------------------------------------
    // Lane FIFOs
    // ----------------------------------------------------------------
    for (genvar i = 0; i < `MERGE_LANES; i++) begin : gen_lane_fifo
        assign lane_ready[i]                 = ~lane_full[i];
        assign {fifo_meta[i], fifo_field[i]} = lane_dout[i];

        merge_fifo #(
            .WIDTH      (LANE_W),
            .DEPTH      (`MERGE_FIFO_DEPTH),
            .PROG_THRESH(`MERGE_PROG_THRESH)
        ) u_lane_fifo (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .wr_en           (lane_valid[i] & lane_ready[i]),
            .din             ({lane_meta[i], lane_field[i]}),
            .rd_en           (lane_pop[i]),
            .dout            (lane_dout[i]),
            .empty           (lane_empty[i]),
            .full            (lane_full[i]),
            .prog_full       ()
        );
    end

    // ----------------------------------------------------------------
    // Control and merge
    // ----------------------------------------------------------------
    merge_control u_merge_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_req         (cfg_req),
        .cfg_mask        (cfg_mask),
        .cfg_count       (cfg_count),
        .merge_fire      (merge_fire),
        .prog_full       (out_prog_full),
        .cfg_ack         (cfg_ack),
        .lane_mask       (lane_mask),
        .run             (run),
        .done            (done)
    );

    merge_combiner u_merge_combiner (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .run             (run),
        .lane_mask       (lane_mask),
        .lane_empty      (lane_empty),
        .lane_meta       (fifo_meta),
        .lane_field      (fifo_field),
        .lane_pop        (lane_pop),
        .merge_fire      (merge_fire),
        .pkt_meta        (pkt_meta),
        .pkt_data        (pkt_data)
    );

    // ----------------------------------------------------------------
    // Output FIFO
    // ----------------------------------------------------------------
    // Pops while empty are dropped here
    assign out_rd                = out_pop & ~out_empty;
    assign out_valid             = ~out_empty;
    assign {out_meta, out_data}  = out_dout;

    merge_fifo #(
        .WIDTH      (OUT_W),
        .DEPTH      (`MERGE_FIFO_DEPTH),
        .PROG_THRESH(`MERGE_PROG_THRESH)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (merge_fire),
        .din             ({pkt_meta, pkt_data}),
        .rd_en           (out_rd),
        .dout            (out_dout),
        .empty           (out_empty),
        .full            (),
        .prog_full       (out_prog_full)
    );

endmodule : merge_data_generator

// File: dv/merge_data_generator_tb.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Testbench for the merge data generator
// Table of runs, reference model, value checker and cycle limit
// ----------------------------------------------------------------------

`include "merge_cfg.svh"

module merge_data_generator_tb;

    import merge_pkg::*;

    localparam int LANES       = `MERGE_LANES;
    localparam int FW          = `MERGE_FIELD_W;
    localparam int MAX_WORDS   = 64;
    localparam int NUM_ROWS    = 5;
    localparam int HOLD_CYCLES = 30;

    typedef enum logic [1:0] {POP_ALWAYS, POP_RANDOM, POP_HOLD} pop_mode_t;

    typedef struct packed {
        lane_mask_t mask;
        pkt_count_t count;
        pop_mode_t  pop_mode;
    } row_t;

    // Lane 0 stays enabled in every run since it carries the meta word
    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'b1111, 16'd12, POP_ALWAYS},
        '{4'b0101, 16'd10, POP_RANDOM},
        '{4'b1111, 16'd40, POP_HOLD},
        '{4'b1011, 16'd16, POP_RANDOM},
        '{4'b0001, 16'd6,  POP_ALWAYS}
    };

    logic             ap_clk;
    logic             areset_generator;
    logic             cfg_req;
    lane_mask_t       cfg_mask;
    pkt_count_t       cfg_count;
    logic [LANES-1:0] lane_valid;
    meta_t            lane_meta [LANES];
    field_t           lane_field [LANES];
    logic             out_pop;
    logic             cfg_ack;
    logic             done;
    logic [LANES-1:0] lane_ready;
    logic             out_valid;
    meta_t            out_meta;
    packet_data_t     out_data;

    // Words offered on each lane during the current run
    meta_t  word_meta [LANES][MAX_WORDS];
    field_t word_field [LANES][MAX_WORDS];

    merge_data_generator u_merge_data_generator (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_req         (cfg_req),
        .cfg_mask        (cfg_mask),
        .cfg_count       (cfg_count),
        .lane_valid      (lane_valid),
        .lane_meta       (lane_meta),
        .lane_field      (lane_field),
        .out_pop         (out_pop),
        .cfg_ack         (cfg_ack),
        .done            (done),
        .lane_ready      (lane_ready),
        .out_valid       (out_valid),
        .out_meta        (out_meta),
        .out_data        (out_data)
    );

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------------
    // Helpers and reference model
    // ------------------------------------------------------------------
    task automatic check_value(input logic [159:0] actual, input logic [159:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic int timeout_limit();
        int limit;
        int r;
        limit = 200;
        for (r = 0; r < NUM_ROWS; r++) begin
            limit += int'(ROWS[r].count) * 8;
        end
        return limit;
    endfunction

    // Enabled lanes give their word k to packet k and masked lanes give zero
    function automatic packet_data_t expected_data(input lane_mask_t mask, input int k);
        packet_data_t data;
        int           lane;
        data = '0;
        for (lane = 0; lane < LANES; lane++) begin
            if (mask[lane]) begin
                data[lane*FW +: FW] = word_field[lane][k];
            end
        end
        return data;
    endfunction

    task automatic fill_lane_words(input int count);
        int lane;
        int k;
        for (lane = 0; lane < LANES; lane++) begin
            for (k = 0; k < count; k++) begin
                word_meta[lane][k]  = meta_t'($urandom);
                word_field[lane][k] = $urandom;
            end
        end
    endtask

    // Four-phase request and acknowledge with one cycle per step
    task automatic run_handshake(input lane_mask_t mask, input pkt_count_t count);
        int wait_cycles;
        check_value(cfg_ack, 1'b0, "cfg_ack low before the request");
        cfg_mask    = mask;
        cfg_count   = count;
        cfg_req     = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge ap_clk);
            #2;
            wait_cycles++;
        end while (!cfg_ack);
        check_value(wait_cycles, 1, "cycles from cfg_req rise to cfg_ack rise");
        check_value(done, 1'b0, "done low once cfg_ack is high");
        cfg_req     = 1'b0;
        wait_cycles = 0;
        do begin
            @(posedge ap_clk);
            #2;
            wait_cycles++;
        end while (cfg_ack);
        check_value(wait_cycles, 1, "cycles from cfg_req fall to cfg_ack fall");
    endtask

    // ------------------------------------------------------------------
    // One table row configures the run, feeds the lanes, collects packets
    // ------------------------------------------------------------------
    task automatic run_row(input int r);
        row_t             row;
        int               fed [LANES];
        logic [LANES-1:0] accept;
        int               received;
        int               row_cycle;
        int               lane;
        logic             all_fed;
        logic             finished;
        logic             pop;
        logic             saw_backpressure;
        row = ROWS[r];
        fill_lane_words(int'(row.count));
        if (r > 0) begin
            check_value(done, 1'b1, "done held high until the next request");
        end
        run_handshake(row.mask, row.count);
        for (lane = 0; lane < LANES; lane++) begin
            fed[lane] = 0;
        end
        accept           = '0;
        received         = 0;
        row_cycle        = 0;
        finished         = 1'b0;
        saw_backpressure = 1'b0;
        while (!finished) begin
            // Transfers decided before the last edge
            for (lane = 0; lane < LANES; lane++) begin
                if (accept[lane]) begin
                    fed[lane]++;
                end
            end
            all_fed = 1'b1;
            for (lane = 0; lane < LANES; lane++) begin
                if (fed[lane] < int'(row.count)) begin
                    all_fed = 1'b0;
                end
            end
            if (all_fed && received == int'(row.count)) begin
                finished = 1'b1;
            end
            else begin
                for (lane = 0; lane < LANES; lane++) begin
                    lane_valid[lane] = (fed[lane] < int'(row.count));
                    if (lane_valid[lane]) begin
                        lane_meta[lane]  = word_meta[lane][fed[lane]];
                        lane_field[lane] = word_field[lane][fed[lane]];
                    end
                end
                accept = lane_valid & lane_ready;
                if (lane_ready != '1) begin
                    saw_backpressure = 1'b1;
                end
                case (row.pop_mode)
                    POP_ALWAYS: pop = 1'b1;
                    POP_RANDOM: pop = (($urandom % 4) != 0);
                    default:    pop = (row_cycle >= HOLD_CYCLES);
                endcase
                if (pop && out_valid && received < int'(row.count)) begin
                    check_value(out_meta, word_meta[0][received],
                                $sformatf("row %0d packet %0d meta", r, received));
                    check_value(out_data, expected_data(row.mask, received),
                                $sformatf("row %0d packet %0d data", r, received));
                    received++;
                    if (received == int'(row.count)) begin
                        check_value(done, 1'b1, "done high at the last packet");
                    end
                end
                out_pop = pop;
                @(posedge ap_clk);
                #2;
                row_cycle++;
            end
        end
        lane_valid = '0;
        out_pop    = 1'b0;
        if (row.pop_mode == POP_HOLD) begin
            check_value(saw_backpressure, 1'b1, "lane_ready drop while out_pop held off");
        end
        // Nothing beyond the configured count
        repeat (4) begin
            @(posedge ap_clk);
            #2;
            check_value(out_valid, 1'b0, $sformatf("row %0d extra packet", r));
            check_value(done, 1'b1, $sformatf("row %0d done after the run", r));
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int r;
        int lane;
        areset_generator = 1'b1;
        cfg_req          = 1'b0;
        cfg_mask         = '0;
        cfg_count        = '0;
        lane_valid       = '0;
        out_pop          = 1'b0;
        for (lane = 0; lane < LANES; lane++) begin
            lane_meta[lane]  = '0;
            lane_field[lane] = '0;
        end
        void'($urandom(32'h3391_9ba8));
        repeat (2) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;
        check_value(cfg_ack, 1'b0, "cfg_ack after reset");
        check_value(done, 1'b0, "done after reset");
        check_value(out_valid, 1'b0, "out_valid after reset");
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("TEST PASS");
        $finish;
    end

    initial begin
        int cycle_count;
        int limit;
        cycle_count = 0;
        limit       = timeout_limit();
        while (cycle_count < limit) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped by the cycle limit");
    end

endmodule : merge_data_generator_tb

// File: build.f
+incdir+include
logic/merge_pkg.sv
logic/merge_fifo.sv
logic/merge_control.sv
logic/merge_combiner.sv
logic/merge_data_generator.sv
dv/merge_data_generator_tb.sv

// File: Makefile
# Verilator build and run of the merge data generator testbench

TOP := merge_data_generator_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   list these targets"

test:
	rm -rf obj_dir sim.log
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	-./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "No pass line found in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
